// File: hdl/icache_pkg.sv
// Instruction cache widths, cache line union and refill state encoding

package icache_pkg;

    // ----------------------------------------
    // Address and bus widths
    // ----------------------------------------

    // Fetch and AXI address width
    localparam int ADDR_W   = 32;

    // Byte offset within a 16-byte line
    localparam int OFFSET_W = 4;

    // Set index, 64 sets
    localparam int INDEX_W  = 6;

    // Whatever is left above index and offset
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    // AXI read data bus, two beats per line
    localparam int BEAT_W   = 64;

    // ----------------------------------------
    // Cache line
    // ----------------------------------------

    // Same 128 bits seen by the fetch side as words and by the bus side as beats.
    // Index 0 of either view sits at the lowest address
    typedef union packed {
        logic [3:0][31:0]       words;
        logic [1:0][BEAT_W-1:0] beats;
    } cache_line_t;

    // ----------------------------------------
    // Refill FSM
    // ----------------------------------------

    // FILL0/FILL1 wait for the lower and upper beat
    // DONE holds the refilled word until taken
    // DRAIN swallows a beat left over from a flush
    typedef enum logic [2:0] {
        IDLE,
        FILL0,
        FILL1,
        DONE,
        DRAIN
    } refill_state_t;

endpackage

// File: hdl/icache_lookup.sv
// Lookup stage: fetch handshake, compare-stage register and array read index
`timescale 1ns/1ns

module icache_lookup #(
    parameter int NUM_SETS = 64
) (
    input  logic                        clk,
    input  logic                        reset,

    // Fetch request
    input  logic                        req_valid,
    input  logic [icache_pkg::ADDR_W-1:0] req_addr,
    output logic                        req_allowin,
    input  logic                        flush,

    // Compare stage
    output logic                        cs_valid,
    output logic [icache_pkg::ADDR_W-1:0] cs_addr,
    input  logic                        cs_done,

    // Array read port
    output logic [icache_pkg::INDEX_W-1:0] rd_index
);

    import icache_pkg::*;

    // Keeps the index inside the sets that actually exist
    localparam logic [INDEX_W-1:0] SET_MASK = INDEX_W'(NUM_SETS - 1);

    logic               accept;
    logic [INDEX_W-1:0] req_index;
    logic [INDEX_W-1:0] held_index;

    // ----------------------------------------
    // Handshake
    // ----------------------------------------

    // Stage can take a new entry when empty or when the held one leaves now.
    // A flushed cycle takes nothing
    assign req_allowin = !flush && (!cs_valid || cs_done);
    assign accept      = req_valid && req_allowin;

    // ----------------------------------------
    // Stage register
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            cs_valid <= 1'b0;
        end else if (accept) begin
            cs_valid <= 1'b1;
        end else if (cs_done) begin
            cs_valid <= 1'b0;
        end
    end

    // Address is payload only
    always_ff @(posedge clk) begin
        if (accept) begin
            cs_addr <= req_addr;
        end
    end

    // ----------------------------------------
    // Read index
    // ----------------------------------------

    assign req_index  = req_addr[OFFSET_W +: INDEX_W] & SET_MASK;
    assign held_index = cs_addr[OFFSET_W +: INDEX_W] & SET_MASK;

    // A stalled entry keeps re-reading its own set, so a refill write
    // to that set shows up on the array outputs
    assign rd_index = accept ? req_index : held_index;

endmodule

// File: hdl/icache_arrays.sv
// Two-way tag, valid and line storage with registered read and write forwarding
`timescale 1ns/1ns

module icache_arrays #(
    parameter int NUM_SETS = 64
) (
    input  logic                           clk,
    input  logic                           reset,

    // Read port
    input  logic [icache_pkg::INDEX_W-1:0] rd_index,
    output logic [icache_pkg::TAG_W-1:0]   tag0,
    output logic [icache_pkg::TAG_W-1:0]   tag1,
    output logic                           valid0,
    output logic                           valid1,
    output icache_pkg::cache_line_t        line0,
    output icache_pkg::cache_line_t        line1,

    // Refill write port
    input  logic                           wr_en,
    input  logic                           wr_way,
    input  logic [icache_pkg::INDEX_W-1:0] wr_index,
    input  logic [icache_pkg::TAG_W-1:0]   wr_tag,
    input  icache_pkg::cache_line_t        wr_line
);

    import icache_pkg::*;

    logic [TAG_W-1:0]    tag_mem   [2][NUM_SETS];
    cache_line_t         line_mem  [2][NUM_SETS];
    logic [NUM_SETS-1:0] valid_mem [2];

    logic [TAG_W-1:0]    rd_tag    [2];
    cache_line_t         rd_line   [2];
    logic                rd_valid  [2];

    logic                fwd       [2];

    // Write lands on the set being read in the same cycle
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            fwd[w] = wr_en && (wr_way == w[0]) && (wr_index == rd_index);
        end
    end

    // ----------------------------------------
    // Tags and lines
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_way][wr_index]  <= wr_tag;
            line_mem[wr_way][wr_index] <= wr_line;
        end
        for (int w = 0; w < 2; w++) begin
            if (fwd[w]) begin
                rd_tag[w]  <= wr_tag;
                rd_line[w] <= wr_line;
            end else begin
                rd_tag[w]  <= tag_mem[w][rd_index];
                rd_line[w] <= line_mem[w][rd_index];
            end
        end
    end

    // ----------------------------------------
    // Valid bits
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < 2; w++) begin
                valid_mem[w] <= '0;
                rd_valid[w]  <= 1'b0;
            end
        end else begin
            if (wr_en) begin
                valid_mem[wr_way][wr_index] <= 1'b1;
            end
            for (int w = 0; w < 2; w++) begin
                rd_valid[w] <= fwd[w] || valid_mem[w][rd_index];
            end
        end
    end

    assign tag0   = rd_tag[0];
    assign tag1   = rd_tag[1];
    assign valid0 = rd_valid[0];
    assign valid1 = rd_valid[1];
    assign line0  = rd_line[0];
    assign line1  = rd_line[1];

endmodule

// File: hdl/icache_compare.sv
// Compare stage: hit check, refill FSM, word select, victim bit and flush drain
`timescale 1ns/1ns

module icache_compare (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           flush,

    // Held entry from the lookup stage
    input  logic                           cs_valid,
    input  logic [icache_pkg::ADDR_W-1:0]  cs_addr,
    output logic                           cs_done,

    // Array read data
    input  logic [icache_pkg::TAG_W-1:0]   tag0,
    input  logic [icache_pkg::TAG_W-1:0]   tag1,
    input  logic                           valid0,
    input  logic                           valid1,
    input  icache_pkg::cache_line_t        line0,
    input  icache_pkg::cache_line_t        line1,

    // Fetch response
    output logic                           resp_valid,
    output logic [31:0]                    resp_data,
    input  logic                           resp_ready,

    // Array write
    output logic                           wr_en,
    output logic                           wr_way,
    output logic [icache_pkg::INDEX_W-1:0] wr_index,
    output logic [icache_pkg::TAG_W-1:0]   wr_tag,
    output icache_pkg::cache_line_t        wr_line,

    // Beat requests to the AXI reader
    output logic                           beat_req,
    output logic [icache_pkg::ADDR_W-1:0]  beat_addr,
    input  logic                           beat_ack,
    input  logic [icache_pkg::BEAT_W-1:0]  beat_data
);

    import icache_pkg::*;

    refill_state_t state;
    refill_state_t state_next;

    logic [TAG_W-1:0]   cs_tag;
    logic [INDEX_W-1:0] cs_index;
    logic [1:0]         word_sel;

    logic        hit0;
    logic        hit1;
    logic        hit;
    logic        hit_ok;
    logic        miss_start;
    logic        victim;
    cache_line_t hit_line;
    cache_line_t refill_line;

    // ----------------------------------------
    // Address split and hit check
    // ----------------------------------------

    assign cs_tag   = cs_addr[ADDR_W-1 -: TAG_W];
    assign cs_index = cs_addr[OFFSET_W +: INDEX_W];
    assign word_sel = cs_addr[OFFSET_W-1:2];

    assign hit0     = valid0 && (tag0 == cs_tag);
    assign hit1     = valid1 && (tag1 == cs_tag);
    assign hit      = hit0 || hit1;
    assign hit_line = hit0 ? line0 : line1;

    // Hits may still be served while a dropped beat drains
    assign hit_ok     = (state == IDLE) || (state == DRAIN);
    assign miss_start = (state == IDLE) && cs_valid && !flush && !hit;

    // ----------------------------------------
    // Response side
    // ----------------------------------------

    assign resp_valid = cs_valid && !flush &&
                        ((state == DONE) || (hit_ok && hit));

    assign resp_data = (state == DONE) ? refill_line.words[word_sel]
                                       : hit_line.words[word_sel];

    // Entry leaves on a taken response or on flush
    assign cs_done = cs_valid && (flush || (resp_valid && resp_ready));

    // ----------------------------------------
    // Refill FSM
    // ----------------------------------------

    always_comb begin
        state_next = state;
        unique case (state)
            IDLE: begin
                if (miss_start) begin
                    state_next = FILL0;
                end
            end
            FILL0: begin
                if (flush) begin
                    state_next = beat_ack ? IDLE : DRAIN;
                end else if (beat_ack) begin
                    state_next = FILL1;
                end
            end
            FILL1: begin
                if (flush) begin
                    state_next = beat_ack ? IDLE : DRAIN;
                end else if (beat_ack) begin
                    state_next = DONE;
                end
            end
            DONE: begin
                if (flush || resp_ready) begin
                    state_next = IDLE;
                end
            end
            DRAIN: begin
                if (beat_ack) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= IDLE;
            victim <= 1'b0;
        end else begin
            state <= state_next;
            // Round-robin after every completed refill
            if (wr_en) begin
                victim <= ~victim;
            end
        end
    end

    // Beats collected through the bus view
    always_ff @(posedge clk) begin
        if (beat_ack && state == FILL0) begin
            refill_line.beats[0] <= beat_data;
        end
        if (beat_ack && state == FILL1) begin
            refill_line.beats[1] <= beat_data;
        end
    end

    // ----------------------------------------
    // Bus requests
    // ----------------------------------------

    // First beat on the miss, second as soon as the first returns
    assign beat_req  = miss_start || (state == FILL0 && beat_ack && !flush);
    assign beat_addr = {cs_addr[ADDR_W-1:OFFSET_W], (state == FILL0), 3'b000};

    // ----------------------------------------
    // Array write
    // ----------------------------------------

    // Line goes in together with the upper beat
    assign wr_en    = (state == FILL1) && beat_ack && !flush;
    assign wr_way   = victim;
    assign wr_index = cs_index;
    assign wr_tag   = cs_tag;

    always_comb begin
        wr_line.beats[0] = refill_line.beats[0];
        wr_line.beats[1] = beat_data;
    end

endmodule

// File: hdl/icache_axi_reader.sv
// AXI4-Lite read master: one beat request becomes one AR and one R transfer
`timescale 1ns/1ns

module icache_axi_reader (
    input  logic                          clk,
    input  logic                          reset,

    // Beat request from the compare stage
    input  logic                          beat_req,
    input  logic [icache_pkg::ADDR_W-1:0] beat_addr,
    output logic                          beat_ack,
    output logic [icache_pkg::BEAT_W-1:0] beat_data,

    // AR channel
    output logic [icache_pkg::ADDR_W-1:0] araddr,
    output logic [2:0]                    arprot,
    output logic                          arvalid,
    input  logic                          arready,

    // R channel
    input  logic [icache_pkg::BEAT_W-1:0] rdata,
    input  logic [1:0]                    rresp,
    input  logic                          rvalid,
    output logic                          rready
);

    // Unprivileged, secure, instruction fetch
    assign arprot = 3'b100;

    // ----------------------------------------
    // Address then data phase
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            arvalid  <= 1'b0;
            rready   <= 1'b0;
            beat_ack <= 1'b0;
        end else begin
            beat_ack <= 1'b0;
            if (beat_req && !arvalid && !rready) begin
                arvalid <= 1'b1;
            end else if (arvalid && arready) begin
                arvalid <= 1'b0;
                rready  <= 1'b1;
            end else if (rready && rvalid) begin
                rready   <= 1'b0;
                beat_ack <= 1'b1;
            end
        end
    end

    // Address held stable while ARVALID waits
    always_ff @(posedge clk) begin
        if (beat_req && !arvalid && !rready) begin
            araddr <= beat_addr;
        end
    end

    // Data registered, ack follows the R handshake by one cycle
    always_ff @(posedge clk) begin
        if (rready && rvalid) begin
            beat_data <= rdata;
        end
    end

endmodule

// File: hdl/icache_top.sv
// Instruction cache top: lookup, arrays, compare stage and AXI read master
`timescale 1ns/1ns

module icache_top #(
    parameter int NUM_SETS = 64
) (
    input  logic                          clk,
    input  logic                          reset,

    // Fetch side
    input  logic                          req_valid,
    input  logic [icache_pkg::ADDR_W-1:0] req_addr,
    output logic                          req_allowin,
    output logic                          resp_valid,
    output logic [31:0]                   resp_data,
    input  logic                          resp_ready,
    input  logic                          flush,

    // AXI4-Lite read
    output logic [icache_pkg::ADDR_W-1:0] araddr,
    output logic [2:0]                    arprot,
    output logic                          arvalid,
    input  logic                          arready,
    input  logic [icache_pkg::BEAT_W-1:0] rdata,
    input  logic [1:0]                    rresp,
    input  logic                          rvalid,
    output logic                          rready
);

    import icache_pkg::*;

    // ----------------------------------------
    // Stage wiring
    // ----------------------------------------

    logic               cs_valid;
    logic [ADDR_W-1:0]  cs_addr;
    logic               cs_done;
    logic [INDEX_W-1:0] rd_index;

    logic [TAG_W-1:0]   tag0;
    logic [TAG_W-1:0]   tag1;
    logic               valid0;
    logic               valid1;
    cache_line_t        line0;
    cache_line_t        line1;

    logic               wr_en;
    logic               wr_way;
    logic [INDEX_W-1:0] wr_index;
    logic [TAG_W-1:0]   wr_tag;
    cache_line_t        wr_line;

    logic               beat_req;
    logic [ADDR_W-1:0]  beat_addr;
    logic               beat_ack;
    logic [BEAT_W-1:0]  beat_data;

    icache_lookup #(.NUM_SETS(NUM_SETS)) u_lookup (
        .clk(clk), .reset(reset),
        .req_valid(req_valid), .req_addr(req_addr), .req_allowin(req_allowin),
        .flush(flush),
        .cs_valid(cs_valid), .cs_addr(cs_addr), .cs_done(cs_done),
        .rd_index(rd_index)
    );

    icache_arrays #(.NUM_SETS(NUM_SETS)) u_arrays (
        .clk(clk), .reset(reset),
        .rd_index(rd_index),
        .tag0(tag0), .tag1(tag1), .valid0(valid0), .valid1(valid1),
        .line0(line0), .line1(line1),
        .wr_en(wr_en), .wr_way(wr_way), .wr_index(wr_index),
        .wr_tag(wr_tag), .wr_line(wr_line)
    );

    icache_compare u_compare (
        .clk(clk), .reset(reset), .flush(flush),
        .cs_valid(cs_valid), .cs_addr(cs_addr), .cs_done(cs_done),
        .tag0(tag0), .tag1(tag1), .valid0(valid0), .valid1(valid1),
        .line0(line0), .line1(line1),
        .resp_valid(resp_valid), .resp_data(resp_data), .resp_ready(resp_ready),
        .wr_en(wr_en), .wr_way(wr_way), .wr_index(wr_index),
        .wr_tag(wr_tag), .wr_line(wr_line),
        .beat_req(beat_req), .beat_addr(beat_addr),
        .beat_ack(beat_ack), .beat_data(beat_data)
    );

    icache_axi_reader u_axi_reader (
        .clk(clk), .reset(reset),
        .beat_req(beat_req), .beat_addr(beat_addr),
        .beat_ack(beat_ack), .beat_data(beat_data),
        .araddr(araddr), .arprot(arprot), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

endmodule

// File: dv/icache_clkgen.sv
// Testbench clock and synchronous reset generator
`timescale 1ns/1ns

module icache_clkgen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

// File: dv/icache_props.sv
// AXI read channel and fetch response properties, bound into the cache top
`timescale 1ns/1ns

module icache_props (
    input logic                          clk,
    input logic                          reset,
    input logic                          flush,
    input logic                          resp_valid,
    input logic [icache_pkg::ADDR_W-1:0] araddr,
    input logic                          arvalid,
    input logic                          arready,
    input logic                          rvalid,
    input logic                          rready
);

    // Reads accepted on AR and not yet returned on R
    logic [1:0] reads_open;

    always_ff @(posedge clk) begin
        if (reset) begin
            reads_open <= 2'd0;
        end else if (arvalid && arready && !(rvalid && rready)) begin
            reads_open <= reads_open + 2'd1;
        end else if (rvalid && rready && !(arvalid && arready)) begin
            reads_open <= reads_open - 2'd1;
        end
    end

    // Address phase holds until accepted
    ar_stable: assert property (@(posedge clk) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("ARVALID or araddr changed before ARREADY");

    // A stray R beat wraps the count to 3, so it trips here as well
    one_outstanding: assert property (@(posedge clk) disable iff (reset)
        reads_open <= 2'd1)
        else $error("AXI reads out of step, %0d outstanding", reads_open);

    // Flushed entry never answers, in the flush cycle or the one after
    no_resp_on_flush: assert property (@(posedge clk) disable iff (reset)
        (flush || $past(flush)) |-> !resp_valid)
        else $error("resp_valid high during or right after flush");

    resp_low_after_reset: assert property (@(posedge clk)
        reset |=> !resp_valid)
        else $error("resp_valid high right after reset");

endmodule

bind icache_top icache_props u_props (
    .clk(clk), .reset(reset), .flush(flush), .resp_valid(resp_valid),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rvalid(rvalid), .rready(rready)
);

// File: dv/icache_tb.sv
// Cache testbench: stimulus table, set model, AXI memory model, checks and watchdog
`timescale 1ns/1ns

module icache_tb;

    import icache_pkg::*;

    localparam int NUM_TESTS = 16;

    logic clk, reset;
    logic req_valid, req_allowin, resp_valid, resp_ready, flush;
    logic [ADDR_W-1:0] req_addr, araddr;
    logic [31:0] resp_data;
    logic [2:0] arprot;
    logic arvalid, arready, rvalid, rready;
    logic [BEAT_W-1:0] rdata;
    logic [1:0] rresp;

    // Address, flush flag, cycles to hold resp_ready low
    logic [31:0] tbl_addr [NUM_TESTS] = '{
        32'h0000_1000, 32'h0000_1004, 32'h0000_1008, 32'h0000_100c,
        32'h0000_2000, 32'h0000_3000, 32'h0000_2004, 32'h0000_1000,
        32'h0000_3008, 32'h0000_4450, 32'h0000_4454, 32'h0000_4458,
        32'h0000_2000, 32'h0000_1ff0, 32'h8000_0abc, 32'h8000_0ab0};
    logic tbl_flush [NUM_TESTS] = '{
        1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
        1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
    int tbl_hold [NUM_TESTS] = '{0, 0, 3, 0, 1, 0, 0, 2, 0, 0, 4, 0, 0, 2, 0, 5};

    // Set model
    logic [TAG_W-1:0] m_tag [64][2];
    logic m_valid [64][2];
    logic m_victim;

    // AXI memory model state
    int seed = 32'hdbfba459;
    int ar_count;
    logic [31:0] ar_log [256];
    logic ar_armed, r_pend;
    logic [1:0] ar_wait, r_wait;
    logic [31:0] r_addr;

    int errors, passed, failed;

    icache_clkgen #(.PERIOD(20), .RESET_CYCLES(8)) u_clkgen (.clk(clk), .reset(reset));

    icache_top #(.NUM_SETS(64)) DUT (
        .clk(clk), .reset(reset),
        .req_valid(req_valid), .req_addr(req_addr), .req_allowin(req_allowin),
        .resp_valid(resp_valid), .resp_data(resp_data), .resp_ready(resp_ready),
        .flush(flush),
        .araddr(araddr), .arprot(arprot), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return a ^ 32'h5a5a0000;
    endfunction

    // ----------------------------------------
    // AXI memory model
    // ----------------------------------------

    always @(posedge clk) begin
        if (reset) begin
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            ar_armed <= 1'b0;
            r_pend   <= 1'b0;
            ar_count <= 0;
        end else begin
            if (arvalid && arready) begin
                // Every fetch read is an instruction access
                assert (arprot[2] == 1'b1) else begin
                    $display("error %0t arprot[2] got %b expected %b",
                             $time, arprot[2], 1'b1);
                    errors++;
                end
                arready  <= 1'b0;
                ar_armed <= 1'b0;
                r_addr   <= araddr;
                r_wait   <= 2'($random(seed));
                r_pend   <= 1'b1;
                ar_log[ar_count[7:0]] <= araddr;
                ar_count <= ar_count + 1;
            end else if (arvalid) begin
                if (!ar_armed) begin
                    ar_armed <= 1'b1;
                    ar_wait  <= 2'($random(seed));
                end else if (ar_wait == 2'd0) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 2'd1;
                end
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end else if (r_pend) begin
                if (r_wait == 2'd0) begin
                    rvalid <= 1'b1;
                    rdata  <= {mem_word(r_addr + 32'd4), mem_word(r_addr)};
                    r_pend <= 1'b0;
                end else begin
                    r_wait <= r_wait - 2'd1;
                end
            end
        end
    end

    // ----------------------------------------
    // One table entry
    // ----------------------------------------

    task automatic run_entry(input int t);
        logic [31:0] addr, base, exp_word;
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0] tag;
        logic pred_hit;
        int ar_start, lat, err_start;
        addr      = tbl_addr[t];
        idx       = addr[OFFSET_W +: INDEX_W];
        tag       = addr[ADDR_W-1 -: TAG_W];
        base      = {addr[31:4], 4'h0};
        exp_word  = mem_word({addr[31:2], 2'b00});
        pred_hit  = (m_valid[idx][0] && m_tag[idx][0] == tag) ||
                    (m_valid[idx][1] && m_tag[idx][1] == tag);
        err_start = errors;
        ar_start  = ar_count;
        req_valid <= 1'b1;
        req_addr  <= addr;
        @(posedge clk);
        while (!req_allowin) @(posedge clk);
        req_valid <= 1'b0;
        if (tbl_flush[t]) begin
            // Flush once the first beat is on the bus
            while (!arvalid && !resp_valid) @(posedge clk);
            assert (!resp_valid) else begin
                $display("flushed entry %0d responded before its refill started", t);
                errors++;
            end
            flush <= 1'b1;
            @(posedge clk);
            flush <= 1'b0;
            while (arvalid || rready) @(posedge clk);
            repeat (3) begin
                @(posedge clk);
                assert (!resp_valid) else begin
                    $display("flushed entry %0d still produced a response", t);
                    errors++;
                end
            end
        end else begin
            lat = 0;
            do begin
                @(posedge clk);
                lat++;
            end while (!resp_valid);
            if (pred_hit) begin
                assert (lat == 1 && ar_count == ar_start) else begin
                    $display("expected hit took %0d cycles and %0d reads",
                             lat, ar_count - ar_start);
                    errors++;
                end
            end else begin
                assert (ar_count - ar_start == 2) else begin
                    $display("miss made %0d AXI reads instead of 2", ar_count - ar_start);
                    errors++;
                end
                assert (ar_log[ar_start[7:0]] == base) else begin
                    $display("error %0t araddr got %h expected %h",
                             $time, ar_log[ar_start[7:0]], base);
                    errors++;
                end
                assert (ar_log[8'(ar_start + 1)] == base + 32'd8) else begin
                    $display("error %0t araddr got %h expected %h",
                             $time, ar_log[8'(ar_start + 1)], base + 32'd8);
                    errors++;
                end
                m_tag[idx][m_victim]   = tag;
                m_valid[idx][m_victim] = 1'b1;
                m_victim               = ~m_victim;
            end
            assert (resp_data == exp_word) else begin
                $display("error %0t resp_data got %h expected %h", $time, resp_data, exp_word);
                errors++;
            end
            // Response holds still while resp_ready stays low
            repeat (tbl_hold[t]) begin
                @(posedge clk);
                assert (resp_valid) else begin
                    $display("error %0t resp_valid got %b expected %b",
                             $time, resp_valid, 1'b1);
                    errors++;
                end
                assert (resp_data == exp_word) else begin
                    $display("error %0t resp_data got %h expected %h",
                             $time, resp_data, exp_word);
                    errors++;
                end
                assert (!req_allowin) else begin
                    $display("error %0t req_allowin got %b expected %b",
                             $time, req_allowin, 1'b0);
                    errors++;
                end
            end
            resp_ready <= 1'b1;
            @(posedge clk);
            resp_ready <= 1'b0;
        end
        if (errors == err_start) begin
            passed++;
        end else begin
            failed++;
        end
        $display("test %0d addr %h %s: %s", t, addr,
                 tbl_flush[t] ? "flush" : (pred_hit ? "hit" : "miss"),
                 errors == err_start ? "ok" : "FAILED");
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        req_valid  = 1'b0;
        req_addr   = '0;
        resp_ready = 1'b0;
        flush      = 1'b0;
        arready    = 1'b0;
        rvalid     = 1'b0;
        rdata      = '0;
        rresp      = 2'b00;
        errors     = 0;
        passed     = 0;
        failed     = 0;
        m_victim   = 1'b0;
        for (int s = 0; s < 64; s++) begin
            m_valid[s][0] = 1'b0;
            m_valid[s][1] = 1'b0;
        end
        wait (reset === 1'b1);
        wait (reset === 1'b0);
        @(posedge clk);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_entry(t);
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 NUM_TESTS, passed, failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (NUM_TESTS * 40 + 8) @(posedge clk);
        $display("run did not finish within %0d cycles", NUM_TESTS * 40 + 8);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: tb.f
hdl/icache_pkg.sv
hdl/icache_lookup.sv
hdl/icache_arrays.sv
hdl/icache_compare.sv
hdl/icache_axi_reader.sv
hdl/icache_top.sv
dv/icache_clkgen.sv
dv/icache_props.sv
dv/icache_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module icache_tb -Mdir obj_dir -f tb.f > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/Vicache_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
    exit 0
fi
exit 1
